//--- pix_pkg.sv
`default_nettype none

package pix_pkg;

  localparam int word_width = 8;
  localparam int rows       = 4;
  localparam int kh_max     = 3;
  localparam int edge_words = kh_max / 2;
  localparam int in_words   = rows + edge_words;
  localparam int win_words  = rows + 2 * edge_words;

  localparam int cin_max    = 4;
  localparam int cols_max   = 8;
  localparam int blocks_max = 4;
  localparam int edge_depth = cin_max * cols_max;

  localparam int bits_kh        = $clog2(kh_max);
  localparam int bits_kh2       = $clog2((kh_max + 1) / 2);
  localparam int bits_cin       = $clog2(cin_max);
  localparam int bits_cols      = $clog2(cols_max);
  localparam int bits_blocks    = $clog2(blocks_max);
  localparam int bits_edge_addr = $clog2(edge_depth);

  localparam int beat_width    = in_words * word_width;
  localparam int hdr_pad_width = beat_width - bits_kh2 - bits_cin - bits_cols - bits_blocks;

  typedef logic [word_width-1:0] pix_word_t;

  // Header fields hold counts minus one
  typedef struct packed {
    logic [hdr_pad_width-1:0] pad;
    logic [bits_blocks-1:0]   blocks_m1;
    logic [bits_cols-1:0]     cols_m1;
    logic [bits_cin-1:0]      cin_m1;
    logic [bits_kh2-1:0]      kh2;
  } pix_hdr_t;

  typedef union packed {
    pix_word_t [in_words-1:0] pixels;
    pix_hdr_t                 hdr;
  } pix_beat_u;

endpackage

`default_nettype wire

//--- pix_header_decode.sv
`timescale 1ns/100ps
`default_nettype none

module pix_header_decode
  import pix_pkg::*;
(
  input  wire                     aclk,
  input  wire                     aresetn,
  input  wire                     s_valid,
  input  wire                     s_last,
  input  wire pix_beat_u          s_data,
  output logic                    s_ready,
  input  wire                     beat_ready,
  input  wire                     m_last_done,
  output logic                    beat_valid,
  output logic                    cfg_load,
  output logic [bits_kh2-1:0]     kh2,
  output logic [bits_cin-1:0]     cin_m1,
  output logic [bits_cols-1:0]    cols_m1,
  output logic [bits_blocks-1:0]  blocks_m1
);

  typedef enum logic [1:0] {
    st_idle,
    st_pass,
    st_drain
  } state_t;

  state_t state;
  logic   hdr_accept;
  logic   s_last_done;

  assign hdr_accept  = (state == st_idle) && s_valid;
  assign s_last_done = (state == st_pass) && s_valid && beat_ready && s_last;
  assign cfg_load    = hdr_accept;
  assign beat_valid  = (state == st_pass) && s_valid;

  // Pixel beats only pass through while a frame is open
  always_comb begin
    case (state)
      st_idle: s_ready = 1'b1;
      st_pass: s_ready = beat_ready;
      default: s_ready = 1'b0;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:  if (hdr_accept) state <= st_pass;
        st_pass:  if (s_last_done) state <= m_last_done ? st_idle : st_drain;
        st_drain: if (m_last_done) state <= st_idle;
        default:  state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      kh2       <= '0;
      cin_m1    <= '0;
      cols_m1   <= '0;
      blocks_m1 <= '0;
    end else if (hdr_accept) begin
      kh2       <= s_data.hdr.kh2;
      cin_m1    <= s_data.hdr.cin_m1;
      cols_m1   <= s_data.hdr.cols_m1;
      blocks_m1 <= s_data.hdr.blocks_m1;
    end
  end

  // Frame end only arrives while a frame is open
  a_last_in_frame: assert property (@(posedge aclk) disable iff (!aresetn)
    m_last_done |-> (state != st_idle));

endmodule

`default_nettype wire

//--- pix_edge_ram.sv
`timescale 1ns/100ps
`default_nettype none

module pix_edge_ram
  import pix_pkg::*;
(
  input  wire                              aclk,
  input  wire                              wr_en,
  input  wire [bits_edge_addr-1:0]         wr_addr,
  input  wire pix_word_t [edge_words-1:0]  wr_data,
  input  wire                              rd_en,
  input  wire [bits_edge_addr-1:0]         rd_addr,
  output pix_word_t [edge_words-1:0]       rd_data
);

  pix_word_t [edge_words-1:0] mem [edge_depth];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Single-beat blocks read and write address 0 together, new data wins
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      if (wr_en && (wr_addr == rd_addr)) begin
        rd_data <= wr_data;
      end else begin
        rd_data <= mem[rd_addr];
      end
    end
  end

endmodule

`default_nettype wire

//--- pix_shift_exec.sv
`timescale 1ns/100ps
`default_nettype none

module pix_shift_exec
  import pix_pkg::*;
(
  input  wire                        aclk,
  input  wire                        aresetn,
  input  wire                        cfg_load,
  input  wire [bits_kh2-1:0]         kh2,
  input  wire [bits_cin-1:0]         cin_m1,
  input  wire [bits_cols-1:0]        cols_m1,
  input  wire [bits_blocks-1:0]      blocks_m1,
  input  wire                        beat_valid,
  input  wire pix_beat_u             beat_data,
  input  wire                        m_ready,
  input  wire                        out_held,
  output logic                       beat_ready,
  output logic                       load,
  output logic                       kh_last,
  output logic                       frame_last,
  output pix_word_t [win_words-1:0]  win
);

  logic [bits_kh-1:0]         kh_cnt;
  logic [bits_cin-1:0]        ch_cnt;
  logic [bits_cin-1:0]        ch_nxt;
  logic [bits_cols-1:0]       col_cnt;
  logic [bits_cols-1:0]       col_nxt;
  logic [bits_blocks-1:0]     blk_cnt;
  logic [bits_blocks-1:0]     blk_nxt;
  logic                       shift;
  logic                       ch_en;
  logic                       col_en;
  logic                       blk_en;
  logic                       ld_first_blk;
  logic                       ld_last_blk;
  logic                       ld_blk_end;
  logic [bits_edge_addr-1:0]  ptr;
  logic [bits_edge_addr-1:0]  ptr_nxt;
  logic                       edge_wr_en;
  logic                       edge_rd_en;
  pix_word_t [edge_words-1:0] edge_bot;
  pix_word_t [edge_words-1:0] edge_rd;
  pix_word_t [edge_words-1:0] edge_top;

  assign shift      = out_held && m_ready;
  assign kh_last    = kh_cnt == bits_kh'({kh2, 1'b0});
  assign beat_ready = !out_held || (kh_last && m_ready);
  assign load       = beat_valid && beat_ready;

  assign ch_en  = shift && kh_last;
  assign col_en = ch_en && (ch_cnt == cin_m1);
  assign blk_en = col_en && (col_cnt == cols_m1);

  // Next counter values index the beat taken on this edge
  always_comb begin
    ch_nxt  = ch_cnt;
    col_nxt = col_cnt;
    blk_nxt = blk_cnt;
    if (ch_en) ch_nxt = (ch_cnt == cin_m1) ? '0 : ch_cnt + 1'b1;
    if (col_en) col_nxt = (col_cnt == cols_m1) ? '0 : col_cnt + 1'b1;
    if (blk_en) blk_nxt = (blk_cnt == blocks_m1) ? '0 : blk_cnt + 1'b1;
    if (cfg_load) begin
      ch_nxt  = '0;
      col_nxt = '0;
      blk_nxt = '0;
    end
  end

  assign ld_first_blk = blk_nxt == '0;
  assign ld_last_blk  = blk_nxt == blocks_m1;
  assign ld_blk_end   = (ch_nxt == cin_m1) && (col_nxt == cols_m1);
  assign frame_last   = ld_last_blk && ld_blk_end;

  // Edge pointer restarts with every block
  always_comb begin
    ptr_nxt = ptr;
    if (cfg_load || (load && ld_blk_end)) ptr_nxt = '0;
    else if (load) ptr_nxt = ptr + 1'b1;
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      kh_cnt  <= '0;
      ch_cnt  <= '0;
      col_cnt <= '0;
      blk_cnt <= '0;
      ptr     <= '0;
    end else begin
      ch_cnt  <= ch_nxt;
      col_cnt <= col_nxt;
      blk_cnt <= blk_nxt;
      ptr     <= ptr_nxt;
      if (cfg_load || ch_en) kh_cnt <= '0;
      else if (shift) kh_cnt <= kh_cnt + 1'b1;
    end
  end

  assign edge_bot   = beat_data.pixels[in_words-1:rows];
  assign edge_wr_en = load && !ld_last_blk;
  assign edge_rd_en = load || cfg_load;
  assign edge_top   = ld_first_blk ? '0 : edge_rd;

  pix_edge_ram u_edge_ram (
    .aclk    (aclk),
    .wr_en   (edge_wr_en),
    .wr_addr (ptr),
    .wr_data (edge_bot),
    .rd_en   (edge_rd_en),
    .rd_addr (ptr_nxt),
    .rd_data (edge_rd)
  );

  always_ff @(posedge aclk) begin
    if (load) win <= {beat_data.pixels, edge_top};
    else if (shift) win <= {pix_word_t'('0), win[win_words-1:1]};
  end

  // Kernel count only moves off zero while the result stage holds the window
  a_kh_held: assert property (@(posedge aclk) disable iff (!aresetn)
    (kh_cnt != '0) |-> out_held);

endmodule

`default_nettype wire

//--- pix_result.sv
`timescale 1ns/100ps
`default_nettype none

module pix_result
  import pix_pkg::*;
(
  input  wire                             aclk,
  input  wire                             aresetn,
  input  wire pix_word_t [win_words-1:0]  win,
  input  wire [bits_kh2-1:0]              kh2,
  input  wire                             load,
  input  wire                             kh_last,
  input  wire                             frame_last,
  input  wire                             m_ready,
  output logic                            out_held,
  output logic                            m_valid,
  output logic                            m_last,
  output pix_word_t [rows-1:0]            m_data
);

  logic last_reg;
  logic final_shift;

  assign final_shift = m_valid && m_ready && kh_last;
  assign out_held    = m_valid;
  assign m_last      = last_reg && kh_last;

  // Smaller kernels start lower in the window
  always_comb begin
    for (int r = 0; r < rows; r++) begin
      m_data[r] = win[r + edge_words - int'(kh2)];
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_valid  <= 1'b0;
      last_reg <= 1'b0;
    end else if (load) begin
      m_valid  <= 1'b1;
      last_reg <= frame_last;
    end else if (final_shift) begin
      m_valid  <= 1'b0;
      last_reg <= 1'b0;
    end
  end

  a_out_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_data) && $stable(m_last)));

endmodule

`default_nettype wire

//--- pix_stream_top.sv
`timescale 1ns/100ps
`default_nettype none

module pix_stream_top
  import pix_pkg::*;
(
  input  wire                   aclk,
  input  wire                   aresetn,
  input  wire                   s_valid,
  output logic                  s_ready,
  input  wire                   s_last,
  input  wire pix_beat_u        s_data,
  output logic                  m_valid,
  input  wire                   m_ready,
  output logic                  m_last,
  output pix_word_t [rows-1:0]  m_data
);

  logic                      beat_valid;
  logic                      beat_ready;
  logic                      cfg_load;
  logic [bits_kh2-1:0]       kh2;
  logic [bits_cin-1:0]       cin_m1;
  logic [bits_cols-1:0]      cols_m1;
  logic [bits_blocks-1:0]    blocks_m1;
  logic                      load;
  logic                      kh_last;
  logic                      frame_last;
  logic                      out_held;
  pix_word_t [win_words-1:0] win;
  wire                       m_last_done = m_valid && m_ready && m_last;

  pix_header_decode u_decode (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .s_valid     (s_valid),
    .s_last      (s_last),
    .s_data      (s_data),
    .s_ready     (s_ready),
    .beat_ready  (beat_ready),
    .m_last_done (m_last_done),
    .beat_valid  (beat_valid),
    .cfg_load    (cfg_load),
    .kh2         (kh2),
    .cin_m1      (cin_m1),
    .cols_m1     (cols_m1),
    .blocks_m1   (blocks_m1)
  );

  pix_shift_exec u_exec (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .cfg_load   (cfg_load),
    .kh2        (kh2),
    .cin_m1     (cin_m1),
    .cols_m1    (cols_m1),
    .blocks_m1  (blocks_m1),
    .beat_valid (beat_valid),
    .beat_data  (s_data),
    .m_ready    (m_ready),
    .out_held   (out_held),
    .beat_ready (beat_ready),
    .load       (load),
    .kh_last    (kh_last),
    .frame_last (frame_last),
    .win        (win)
  );

  pix_result u_result (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .win        (win),
    .kh2        (kh2),
    .load       (load),
    .kh_last    (kh_last),
    .frame_last (frame_last),
    .m_ready    (m_ready),
    .out_held   (out_held),
    .m_valid    (m_valid),
    .m_last     (m_last),
    .m_data     (m_data)
  );

endmodule

`default_nettype wire

//--- tb_pix_model.svh
`ifndef TB_PIX_MODEL_SVH
`define TB_PIX_MODEL_SVH

// Galois LFSR state, one step per random bit
logic [31:0] lfsr = 32'ha356_6fb7;

function automatic logic [31:0] lfsr_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr[0]};
    if (lfsr[0])
      lfsr = (lfsr >> 1) ^ 32'h8020_0003;
    else
      lfsr = lfsr >> 1;
  end
  return v;
endfunction

// Queues one frame of input beats and the outputs it should produce
task automatic build_frame(
  input logic [bits_kh2-1:0]    kh2,
  input logic [bits_cin-1:0]    cin_m1,
  input logic [bits_cols-1:0]   cols_m1,
  input logic [bits_blocks-1:0] blocks_m1
);
  pix_beat_u                  beat;
  pix_word_t [win_words-1:0]  win;
  pix_word_t [rows-1:0]       exp;
  pix_word_t [edge_words-1:0] bottom [cin_max][cols_max];
  int                         total;
  int                         n_out;
  int                         idx;
  beat = '0;
  beat.hdr.kh2       = kh2;
  beat.hdr.cin_m1    = cin_m1;
  beat.hdr.cols_m1   = cols_m1;
  beat.hdr.blocks_m1 = blocks_m1;
  beat_q.push_back(beat);
  last_q.push_back(1'b0);
  total = (int'(blocks_m1) + 1) * (int'(cols_m1) + 1) * (int'(cin_m1) + 1)
          * (2 * int'(kh2) + 1);
  n_out = 0;
  for (int b = 0; b <= int'(blocks_m1); b++) begin
    for (int c = 0; c <= int'(cols_m1); c++) begin
      for (int ch = 0; ch <= int'(cin_m1); ch++) begin
        for (int w = 0; w < in_words; w++) begin
          beat.pixels[w] = pix_word_t'(lfsr_bits(word_width));
        end
        beat_q.push_back(beat);
        last_q.push_back(b == int'(blocks_m1) && c == int'(cols_m1) && ch == int'(cin_m1));
        // Top edge comes from the block above, zero for the first block
        for (int e = 0; e < edge_words; e++) begin
          win[e] = (b == 0) ? '0 : bottom[ch][c][e];
          bottom[ch][c][e] = beat.pixels[rows + e];
        end
        for (int w = 0; w < in_words; w++) begin
          win[edge_words + w] = beat.pixels[w];
        end
        for (int s = 0; s <= 2 * int'(kh2); s++) begin
          for (int r = 0; r < rows; r++) begin
            idx = r + edge_words - int'(kh2) + s;
            exp[r] = (idx < win_words) ? win[idx] : '0;
          end
          n_out++;
          exp_q.push_back(exp);
          exp_last_q.push_back(n_out == total);
        end
      end
    end
  end
  out_total += total;
endtask

`endif

//--- tb_pix_stream.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pix_stream
  import pix_pkg::*;
();

  logic                 aclk = 1'b0;
  logic                 aresetn;
  logic                 s_valid;
  logic                 s_ready;
  logic                 s_last;
  pix_beat_u            s_data;
  logic                 m_valid;
  logic                 m_ready;
  logic                 m_last;
  pix_word_t [rows-1:0] m_data;

  pix_beat_u            beat_q [$];
  logic                 last_q [$];
  pix_word_t [rows-1:0] exp_q [$];
  logic                 exp_last_q [$];
  pix_word_t [rows-1:0] held_data;
  logic                 held_last;
  logic                 stall_seen = 1'b0;
  logic                 beat_taken = 1'b0;
  int                   out_total = 0;
  int                   cycle_limit = 0;
  int                   cycles = 0;
  int                   rst_cycles = 0;
  int                   pix_errs = 0;
  int                   last_errs = 0;
  int                   proto_errs = 0;

  `include "tb_pix_model.svh"

  pix_stream_top u_dut (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_last  (s_last),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_last  (m_last),
    .m_data  (m_data)
  );

  always #2 aclk = ~aclk;

  task automatic check_pixels(input pix_word_t [rows-1:0] got,
                              input pix_word_t [rows-1:0] exp, input string what);
    if (got !== exp) begin
      pix_errs++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_last(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      last_errs++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Reset release, input beats with random gaps, random output stalls
  always @(negedge aclk) begin
    if (!aresetn) begin
      if (rst_cycles == 1) aresetn = 1'b1;
      rst_cycles++;
    end else begin
      if (!s_valid || beat_taken) begin
        beat_taken = 1'b0;
        if (beat_q.size() > 0 && lfsr_bits(2) != 0) begin
          s_data  = beat_q.pop_front();
          s_last  = last_q.pop_front();
          s_valid = 1'b1;
        end else begin
          s_valid = 1'b0;
          s_last  = 1'b0;
        end
      end
      m_ready = lfsr_bits(2) != 0;
    end
  end

  always @(posedge aclk) begin
    if (aresetn) begin
      cycles++;
      if (cycles > cycle_limit) begin
        $display("Timeout after %0d cycles, %0d outputs never arrived", cycles, exp_q.size());
        $display("TEST FAILED");
        $finish;
      end else begin
        if (s_valid && s_ready) beat_taken = 1'b1;
        if (cycles == 1 && (!s_ready || m_valid)) begin
          proto_errs++;
          $display("DUT not idle after reset at %0t", $time);
        end
        if (m_valid && !m_ready && s_ready) begin
          proto_errs++;
          $display("s_ready high during an output stall at %0t", $time);
        end
        if (stall_seen && !m_valid) begin
          proto_errs++;
          $display("m_valid dropped during an output stall at %0t", $time);
        end else if (stall_seen) begin
          check_pixels(m_data, held_data, "stalled m_data");
          check_last(m_last, held_last, "stalled m_last");
        end
        stall_seen = m_valid && !m_ready;
        held_data  = m_data;
        held_last  = m_last;
        if (m_valid && m_ready && exp_q.size() == 0) begin
          proto_errs++;
          $display("Output transfer at %0t beyond the expected count", $time);
        end else if (m_valid && m_ready) begin
          check_pixels(m_data, exp_q.pop_front(), "m_data");
          check_last(m_last, exp_last_q.pop_front(), "m_last");
        end
      end
    end
  end

  initial begin
    aresetn = 1'b0;
    s_valid = 1'b0;
    s_last  = 1'b0;
    s_data  = '0;
    m_ready = 1'b0;
    // Fixed frames first, single-beat blocks in the third
    build_frame(1'b0, 2'd1, 3'd2, 2'd1);
    build_frame(1'b1, 2'd1, 3'd3, 2'd2);
    build_frame(1'b1, 2'd0, 3'd0, 2'd3);
    for (int f = 0; f < 4; f++) begin
      build_frame(bits_kh2'(lfsr_bits(bits_kh2)), bits_cin'(lfsr_bits(bits_cin)),
                  bits_cols'(lfsr_bits(bits_cols)), bits_blocks'(lfsr_bits(bits_blocks)));
    end
    cycle_limit = out_total * 4 + 200;
    while (exp_q.size() != 0) @(posedge aclk);
    repeat (10) @(posedge aclk);
    $display("Errors: %0d pixel, %0d last, %0d protocol over %0d outputs",
             pix_errs, last_errs, proto_errs, out_total);
    if (pix_errs + last_errs + proto_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
pix_pkg.sv
pix_header_decode.sv
pix_edge_ram.sv
pix_shift_exec.sv
pix_result.sv
pix_stream_top.sv
tb_pix_stream.sv

//--- Bender.yml
package:
  name: pix_stream

sources:
  - pix_pkg.sv
  - pix_header_decode.sv
  - pix_edge_ram.sv
  - pix_shift_exec.sv
  - pix_result.sv
  - pix_stream_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pix_stream.sv
